// ==== rtl/isa_pkg.sv ====
package isa_pkg;

	typedef logic [31:0] word_t;

	// **************************************************************************
	// major opcodes in bits 6 to 2 of the word.
	// **************************************************************************
	typedef enum logic [4:0] {
		OPC_LUI    = 5'b01101,
		OPC_AUIPC  = 5'b00101,
		OPC_JAL    = 5'b11011,
		OPC_JALR   = 5'b11001,
		OPC_BRANCH = 5'b11000,
		OPC_OP_IMM = 5'b00100,
		OPC_OP     = 5'b01100
	} opcode_e;

	// minor opcode fields of the kept instructions.
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [6:0] F7_ADD  = 7'b0000000;

	// immediate layouts.
	typedef enum logic [2:0] {
		FMT_R,
		FMT_I,
		FMT_S,
		FMT_B,
		FMT_U,
		FMT_J,
		FMT_NONE
	} inst_fmt_e;

endpackage

// ==== rtl/uop_pkg.sv ====
package uop_pkg;

	typedef logic [4:0] reg_idx_t;

	// **************************************************************************
	// operation handed from decode to execute.
	// **************************************************************************
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_ADD_IMM,
		ALU_LUI,
		ALU_AUIPC,
		JUMP_JAL,
		JUMP_JALR,
		BRANCH_EQ,
		NOP
	} exec_op_e;

endpackage

// ==== rtl/instr_decoder.sv ====
module instr_decoder (
	input  isa_pkg::word_t    inst,
	output uop_pkg::reg_idx_t rs1,
	output uop_pkg::reg_idx_t rs2,
	output uop_pkg::reg_idx_t rd,
	output uop_pkg::exec_op_e op,
	output isa_pkg::word_t    imm,
	output logic              reads_rs1,
	output logic              reads_rs2,
	output logic              reg_wen
);

	logic [2:0]         funct3;
	logic [6:0]         funct7;
	isa_pkg::inst_fmt_e fmt;
	logic               fmt_writes;

	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];
	assign rd     = inst[11:7];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	// **************************************************************************
	// operation class and format.
	// **************************************************************************
	always_comb begin
		op        = uop_pkg::NOP;
		fmt       = isa_pkg::FMT_NONE;
		reads_rs1 = 1'b0;
		reads_rs2 = 1'b0;
		case (isa_pkg::opcode_e'(inst[6:2]))
			isa_pkg::OPC_LUI: begin
				op  = uop_pkg::ALU_LUI;
				fmt = isa_pkg::FMT_U;
			end
			isa_pkg::OPC_AUIPC: begin
				op  = uop_pkg::ALU_AUIPC;
				fmt = isa_pkg::FMT_U;
			end
			isa_pkg::OPC_JAL: begin
				op  = uop_pkg::JUMP_JAL;
				fmt = isa_pkg::FMT_J;
			end
			isa_pkg::OPC_JALR: begin
				op        = uop_pkg::JUMP_JALR;
				fmt       = isa_pkg::FMT_I;
				reads_rs1 = 1'b1;
			end
			isa_pkg::OPC_BRANCH: begin
				if (funct3 == isa_pkg::F3_BEQ) begin
					op        = uop_pkg::BRANCH_EQ;
					fmt       = isa_pkg::FMT_B;
					reads_rs1 = 1'b1;
					reads_rs2 = 1'b1;
				end
			end
			isa_pkg::OPC_OP_IMM: begin
				if (funct3 == isa_pkg::F3_ADD) begin
					op        = uop_pkg::ALU_ADD_IMM;
					fmt       = isa_pkg::FMT_I;
					reads_rs1 = 1'b1;
				end
			end
			isa_pkg::OPC_OP: begin
				if (funct3 == isa_pkg::F3_ADD && funct7 == isa_pkg::F7_ADD) begin
					op        = uop_pkg::ALU_ADD;
					fmt       = isa_pkg::FMT_R;
					reads_rs1 = 1'b1;
					reads_rs2 = 1'b1;
				end
			end
			default: ; // unknown words stay NOP.
		endcase
	end

	// sign-extended immediate per layout.
	always_comb begin
		case (fmt)
			isa_pkg::FMT_I: imm = {{20{inst[31]}}, inst[31:20]};
			isa_pkg::FMT_B: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			isa_pkg::FMT_U: imm = {inst[31:12], 12'b0};
			isa_pkg::FMT_J: imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			default:        imm = '0;
		endcase
	end

	assign fmt_writes = (fmt == isa_pkg::FMT_U) || (fmt == isa_pkg::FMT_J) ||
		(fmt == isa_pkg::FMT_I) || (fmt == isa_pkg::FMT_R);
	assign reg_wen = fmt_writes && (rd != '0); // x0 targets write nothing.

endmodule

// ==== rtl/register_file.sv ====
module register_file #(
	parameter int REG_COUNT = 32
) (
	input  logic              clock,
	input  logic              reset,
	input  uop_pkg::reg_idx_t rs1_addr,
	input  uop_pkg::reg_idx_t rs2_addr,
	input  uop_pkg::reg_idx_t wr_addr,
	input  logic              wr_en,
	input  isa_pkg::word_t    wr_data,
	output isa_pkg::word_t    rs1_data,
	output isa_pkg::word_t    rs2_data
);

	localparam int IDX_W = $clog2(REG_COUNT);

	isa_pkg::word_t   regs [REG_COUNT];
	logic [IDX_W-1:0] rs1_idx;
	logic [IDX_W-1:0] rs2_idx;
	logic [IDX_W-1:0] wr_idx;

	// upper index bits are dropped.
	assign rs1_idx = rs1_addr[IDX_W-1:0];
	assign rs2_idx = rs2_addr[IDX_W-1:0];
	assign wr_idx  = wr_addr[IDX_W-1:0];

	assign rs1_data = regs[rs1_idx]; // old value during a same-edge write.
	assign rs2_data = regs[rs2_idx];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_idx != '0) begin
			regs[wr_idx] <= wr_data;
		end
	end

endmodule

// ==== rtl/decode_stage.sv ====
module decode_stage (
	input  logic              clock,
	input  logic              reset,

	input  logic              inst_valid,
	input  isa_pkg::word_t    inst,
	input  isa_pkg::word_t    inst_pc,
	output logic              inst_ready,

	input  uop_pkg::reg_idx_t rs1,
	input  uop_pkg::reg_idx_t rs2,
	input  uop_pkg::reg_idx_t rd,
	input  uop_pkg::exec_op_e op,
	input  isa_pkg::word_t    imm,
	input  logic              reads_rs1,
	input  logic              reads_rs2,
	input  logic              reg_wen,

	input  isa_pkg::word_t    src1,
	input  isa_pkg::word_t    src2,

	input  uop_pkg::reg_idx_t wb_rd,
	input  logic              wb_wen,
	input  logic              wb_fire,
	input  isa_pkg::word_t    wb_value,

	input  logic              redirect_valid,

	output logic              exu_valid,
	input  logic              exu_ready,
	output uop_pkg::exec_op_e exu_op,
	output isa_pkg::word_t    exu_pc,
	output uop_pkg::reg_idx_t exu_rd,
	output logic              exu_wen,
	output isa_pkg::word_t    exu_src1,
	output isa_pkg::word_t    exu_src2,
	output isa_pkg::word_t    exu_imm
);

	logic rs1_own_hit;
	logic rs2_own_hit;
	logic rs1_wb_hit;
	logic rs2_wb_hit;
	logic hazard;
	logic accept;
	logic out_free;
	isa_pkg::word_t src1_fwd;
	isa_pkg::word_t src2_fwd;

	// **************************************************************************
	// hazard detection.
	// **************************************************************************
	// producer still sitting in our own output register.
	assign rs1_own_hit = exu_valid && exu_wen && exu_rd != '0 && reads_rs1 && rs1 == exu_rd;
	assign rs2_own_hit = exu_valid && exu_wen && exu_rd != '0 && reads_rs2 && rs2 == exu_rd;

	// producer in execute's result register.
	assign rs1_wb_hit = wb_wen && wb_rd != '0 && reads_rs1 && rs1 == wb_rd;
	assign rs2_wb_hit = wb_wen && wb_rd != '0 && reads_rs2 && rs2 == wb_rd;

	assign hazard = inst_valid && (rs1_own_hit || rs2_own_hit ||
		(!wb_fire && (rs1_wb_hit || rs2_wb_hit)));

	// value written this edge is not visible in the register file yet.
	assign src1_fwd = (rs1_wb_hit && wb_fire) ? wb_value : src1;
	assign src2_fwd = (rs2_wb_hit && wb_fire) ? wb_value : src2;

	assign out_free   = !exu_valid || exu_ready;
	assign inst_ready = !hazard && out_free;
	assign accept     = inst_valid && inst_ready;

	// **************************************************************************
	// output register.
	// **************************************************************************
	always_ff @(posedge clock) begin
		if (reset) begin
			exu_valid <= 1'b0;
		end else if (redirect_valid) begin
			exu_valid <= 1'b0; // wrong-path word is dropped.
		end else if (accept) begin
			exu_valid <= 1'b1;
		end else if (exu_ready) begin
			exu_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (accept && !redirect_valid) begin
			exu_op   <= op;
			exu_pc   <= inst_pc;
			exu_rd   <= rd;
			exu_wen  <= reg_wen;
			exu_src1 <= src1_fwd;
			exu_src2 <= src2_fwd;
			exu_imm  <= imm;
		end
	end

endmodule

// ==== rtl/execute_stage.sv ====
module execute_stage (
	input  logic              clock,
	input  logic              reset,

	input  logic              exu_valid,
	output logic              exu_ready,
	input  uop_pkg::exec_op_e exu_op,
	input  isa_pkg::word_t    exu_pc,
	input  uop_pkg::reg_idx_t exu_rd,
	input  logic              exu_wen,
	input  isa_pkg::word_t    exu_src1,
	input  isa_pkg::word_t    exu_src2,
	input  isa_pkg::word_t    exu_imm,

	output logic              redirect_valid,
	output isa_pkg::word_t    redirect_pc,

	output uop_pkg::reg_idx_t wb_rd,
	output logic              wb_wen,
	output logic              wb_fire,
	output isa_pkg::word_t    wb_value,

	output logic              retire_valid,
	output isa_pkg::word_t    retire_pc,
	output uop_pkg::reg_idx_t retire_rd,
	output isa_pkg::word_t    retire_value,
	output logic              retire_wen,
	input  logic              retire_ready
);

	logic           accept;
	logic           taken;
	isa_pkg::word_t result;
	isa_pkg::word_t pc_imm;
	isa_pkg::word_t src_imm;

	assign exu_ready = !retire_valid || retire_ready;
	assign accept    = exu_valid && exu_ready;

	// **************************************************************************
	// ALU and control flow.
	// **************************************************************************
	assign pc_imm  = exu_pc + exu_imm;
	assign src_imm = exu_src1 + exu_imm;

	always_comb begin
		case (exu_op)
			uop_pkg::ALU_ADD:     result = exu_src1 + exu_src2;
			uop_pkg::ALU_ADD_IMM: result = src_imm;
			uop_pkg::ALU_LUI:     result = exu_imm;
			uop_pkg::ALU_AUIPC:   result = pc_imm;
			uop_pkg::JUMP_JAL,
			uop_pkg::JUMP_JALR:   result = exu_pc + 32'd4; // link.
			default:              result = '0;
		endcase
	end

	assign taken = (exu_op == uop_pkg::JUMP_JAL) || (exu_op == uop_pkg::JUMP_JALR) ||
		(exu_op == uop_pkg::BRANCH_EQ && exu_src1 == exu_src2);

	assign redirect_valid = accept && taken;
	assign redirect_pc    = (exu_op == uop_pkg::JUMP_JALR) ? {src_imm[31:1], 1'b0} : pc_imm;

	// **************************************************************************
	// result register.
	// **************************************************************************
	always_ff @(posedge clock) begin
		if (reset) begin
			retire_valid <= 1'b0;
		end else if (exu_ready) begin
			retire_valid <= exu_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			retire_pc    <= exu_pc;
			retire_rd    <= exu_rd;
			retire_value <= result;
			retire_wen   <= exu_wen;
		end
	end

	// writeback is the retire handshake itself.
	assign wb_fire  = retire_valid && retire_ready;
	assign wb_wen   = retire_valid && retire_wen;
	assign wb_rd    = retire_rd;
	assign wb_value = retire_value;

endmodule

// ==== rtl/rv_pipe_core.sv ====
module rv_pipe_core #(
	parameter int REG_COUNT = 32
) (
	input  logic              clock,
	input  logic              reset,

	input  logic              inst_valid,
	input  isa_pkg::word_t    inst,
	input  isa_pkg::word_t    inst_pc,
	output logic              inst_ready,

	output logic              redirect_valid,
	output isa_pkg::word_t    redirect_pc,

	output logic              retire_valid,
	output isa_pkg::word_t    retire_pc,
	output uop_pkg::reg_idx_t retire_rd,
	output isa_pkg::word_t    retire_value,
	output logic              retire_wen,
	input  logic              retire_ready
);

	// decoder outputs.
	uop_pkg::reg_idx_t dec_rs1;
	uop_pkg::reg_idx_t dec_rs2;
	uop_pkg::reg_idx_t dec_rd;
	uop_pkg::exec_op_e dec_op;
	isa_pkg::word_t    dec_imm;
	logic              dec_reads_rs1;
	logic              dec_reads_rs2;
	logic              dec_reg_wen;

	isa_pkg::word_t    rf_src1;
	isa_pkg::word_t    rf_src2;

	// decode to execute.
	logic              exu_valid;
	logic              exu_ready;
	uop_pkg::exec_op_e exu_op;
	isa_pkg::word_t    exu_pc;
	uop_pkg::reg_idx_t exu_rd;
	logic              exu_wen;
	isa_pkg::word_t    exu_src1;
	isa_pkg::word_t    exu_src2;
	isa_pkg::word_t    exu_imm;

	// writeback.
	uop_pkg::reg_idx_t wb_rd;
	logic              wb_wen;
	logic              wb_fire;
	isa_pkg::word_t    wb_value;

	instr_decoder u_decoder (
		.inst(inst), .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd), .op(dec_op), .imm(dec_imm),
		.reads_rs1(dec_reads_rs1), .reads_rs2(dec_reads_rs2), .reg_wen(dec_reg_wen)
	);

	register_file #(.REG_COUNT(REG_COUNT)) u_regs (
		.clock(clock), .reset(reset), .rs1_addr(dec_rs1), .rs2_addr(dec_rs2),
		.wr_addr(wb_rd), .wr_en(wb_fire && wb_wen), .wr_data(wb_value),
		.rs1_data(rf_src1), .rs2_data(rf_src2)
	);

	decode_stage u_decode (
		.clock(clock), .reset(reset),
		.inst_valid(inst_valid), .inst(inst), .inst_pc(inst_pc), .inst_ready(inst_ready),
		.rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd), .op(dec_op), .imm(dec_imm),
		.reads_rs1(dec_reads_rs1), .reads_rs2(dec_reads_rs2), .reg_wen(dec_reg_wen),
		.src1(rf_src1), .src2(rf_src2),
		.wb_rd(wb_rd), .wb_wen(wb_wen), .wb_fire(wb_fire), .wb_value(wb_value),
		.redirect_valid(redirect_valid),
		.exu_valid(exu_valid), .exu_ready(exu_ready), .exu_op(exu_op), .exu_pc(exu_pc),
		.exu_rd(exu_rd), .exu_wen(exu_wen), .exu_src1(exu_src1), .exu_src2(exu_src2),
		.exu_imm(exu_imm)
	);

	execute_stage u_execute (
		.clock(clock), .reset(reset),
		.exu_valid(exu_valid), .exu_ready(exu_ready), .exu_op(exu_op), .exu_pc(exu_pc),
		.exu_rd(exu_rd), .exu_wen(exu_wen), .exu_src1(exu_src1), .exu_src2(exu_src2),
		.exu_imm(exu_imm),
		.redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
		.wb_rd(wb_rd), .wb_wen(wb_wen), .wb_fire(wb_fire), .wb_value(wb_value),
		.retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
		.retire_value(retire_value), .retire_wen(retire_wen), .retire_ready(retire_ready)
	);

endmodule

// ==== verification/core_properties.sv ====
module core_properties (
	input logic        clock,
	input logic        reset,
	input logic        redirect_valid,
	input logic        retire_valid,
	input logic        retire_ready,
	input logic        retire_wen,
	input logic [4:0]  retire_rd,
	input logic [31:0] retire_pc,
	input logic [31:0] retire_value
);
	timeunit 1ns;
	timeprecision 1ps;

	// fields hold while the consumer stalls.
	retire_stable: assert property (@(posedge clock) disable iff (reset)
		retire_valid && !retire_ready |=> retire_valid && $stable(retire_pc) &&
		$stable(retire_rd) && $stable(retire_value) && $stable(retire_wen))
		else $error("retire fields changed under back-pressure");

	quiet_after_reset: assert property (@(posedge clock)
		!reset && $past(reset) |-> !retire_valid && !redirect_valid)
		else $error("retire or redirect active right after reset");

	no_x0_write: assert property (@(posedge clock) disable iff (reset)
		retire_valid |-> !(retire_wen && retire_rd == 5'd0))
		else $error("retire writes x0");

endmodule

bind rv_pipe_core core_properties props (
	.clock(clock), .reset(reset), .redirect_valid(redirect_valid),
	.retire_valid(retire_valid), .retire_ready(retire_ready), .retire_wen(retire_wen),
	.retire_rd(retire_rd), .retire_pc(retire_pc), .retire_value(retire_value)
);

// ==== verification/core_tb.sv ====
module core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int REG_COUNT = 32;
	localparam int MAX_LEN = 64;

	logic clock = 1'b0;
	logic reset, inst_valid, inst_ready, redirect_valid;
	logic retire_valid, retire_wen, retire_ready;
	isa_pkg::word_t inst, inst_pc, redirect_pc, retire_pc, retire_value;
	uop_pkg::reg_idx_t retire_rd;

	isa_pkg::word_t prog [MAX_LEN];
	isa_pkg::word_t model_regs [REG_COUNT];
	isa_pkg::word_t exp_pc[$], exp_val[$];
	logic [4:0] exp_rd[$];
	logic exp_wen[$];
	int prog_len, retired, errors, tests, failed_tests;
	logic running, hold_reset, bp_on;
	isa_pkg::word_t fetch_pc;
	logic landing [MAX_LEN];

	rv_pipe_core #(.REG_COUNT(REG_COUNT)) UUT (
		.clock(clock), .reset(reset), .inst_valid(inst_valid), .inst(inst), .inst_pc(inst_pc),
		.inst_ready(inst_ready), .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
		.retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
		.retire_value(retire_value), .retire_wen(retire_wen), .retire_ready(retire_ready)
	);

	always #4 clock = ~clock;

	task automatic check_value(input string name, input isa_pkg::word_t act, exp);
		if (act !== exp) begin
			$display("MISMATCH %s: got %h expected %h", name, act, exp);
			errors++;
		end
	endtask

	// ************************************************************************
	// instruction encoders.
	// ************************************************************************
	function automatic isa_pkg::word_t enc_i(isa_pkg::opcode_e opc, int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], opc, 2'b11};
	endfunction

	function automatic isa_pkg::word_t enc_r(int rd, int rs1, int rs2);
		return {7'b0, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], isa_pkg::OPC_OP, 2'b11};
	endfunction

	function automatic isa_pkg::word_t enc_b(int rs1, int rs2, int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11],
			isa_pkg::OPC_BRANCH, 2'b11};
	endfunction

	function automatic isa_pkg::word_t enc_j(int rd, int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], isa_pkg::OPC_JAL, 2'b11};
	endfunction

	function automatic isa_pkg::word_t random_alu(int nregs, bit with_upper);
		int kind;
		int rd;
		kind = $urandom % (with_upper ? 4 : 2);
		rd = $urandom % nregs;
		case (kind)
			0: return enc_i(isa_pkg::OPC_OP_IMM, rd, $urandom % nregs, int'($urandom % 64) - 32);
			1: return enc_r(rd, $urandom % nregs, $urandom % nregs);
			2: return {20'($urandom), 5'(rd), isa_pkg::OPC_LUI, 2'b11};
			default: return {20'($urandom), 5'(rd), isa_pkg::OPC_AUIPC, 2'b11};
		endcase
	endfunction

	function automatic isa_pkg::word_t read_reg(logic [4:0] idx);
		int f;
		f = idx % REG_COUNT;
		return (f == 0) ? '0 : model_regs[f];
	endfunction

	// ISS step for one word per the RV32I encoding rules.
	function automatic void golden_step(input isa_pkg::word_t pc, output isa_pkg::word_t next_pc,
			output logic [4:0] rd, output isa_pkg::word_t value, output logic wen);
		isa_pkg::word_t w, iimm, bimm, jimm, uimm, t;
		w = prog[pc[31:2]];
		rd = w[11:7];
		iimm = {{20{w[31]}}, w[31:20]};
		bimm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		jimm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		uimm = {w[31:12], 12'b0};
		next_pc = pc + 4;
		value = '0;
		wen = 1'b0;
		case (w[6:2])
			isa_pkg::OPC_LUI: begin
				value = uimm;
				wen = 1'b1;
			end
			isa_pkg::OPC_AUIPC: begin
				value = pc + uimm;
				wen = 1'b1;
			end
			isa_pkg::OPC_JAL: begin
				value = pc + 4;
				wen = 1'b1;
				next_pc = pc + jimm;
			end
			isa_pkg::OPC_JALR: begin
				t = read_reg(w[19:15]) + iimm;
				next_pc = {t[31:1], 1'b0};
				value = pc + 4;
				wen = 1'b1;
			end
			isa_pkg::OPC_BRANCH: begin
				if (w[14:12] == 3'b000 && read_reg(w[19:15]) == read_reg(w[24:20]))
					next_pc = pc + bimm;
			end
			isa_pkg::OPC_OP_IMM: begin
				if (w[14:12] == 3'b000) begin
					value = read_reg(w[19:15]) + iimm;
					wen = 1'b1;
				end
			end
			isa_pkg::OPC_OP: begin
				if (w[14:12] == 3'b000 && w[31:25] == 7'b0) begin
					value = read_reg(w[19:15]) + read_reg(w[24:20]);
					wen = 1'b1;
				end
			end
			default: ;
		endcase
		wen = wen && rd != 5'd0;
		if (wen && rd % REG_COUNT != 0) model_regs[rd % REG_COUNT] = value;
	endfunction

	// ************************************************************************
	// program generators.
	// ************************************************************************
	task automatic gen_dep();
		prog_len = 24;
		prog[0] = enc_i(isa_pkg::OPC_OP_IMM, 1, 0, 5);
		prog[1] = enc_i(isa_pkg::OPC_OP_IMM, 2, 0, 9);
		for (int i = 2; i < prog_len; i++) prog[i] = random_alu(4, 1'b0);
	endtask

	task automatic gen_mix();
		prog_len = 48;
		for (int i = 0; i < prog_len; i++) prog[i] = random_alu(8, 1'b1);
	endtask

	task automatic gen_ctrl();
		int i, k, t;
		prog_len = 48;
		for (int j = 0; j < MAX_LEN; j++) landing[j] = 1'b0;
		i = 0;
		while (i < prog_len) begin
			k = 1 + $urandom % 4;
			t = (i < prog_len - 6) ? $urandom % 5 : 0;
			if (t == 2) begin
				prog[i] = enc_b($urandom % 3, $urandom % 3, k * 4);
				landing[i + k] = 1'b1;
			end else if (t == 3) begin
				prog[i] = enc_j($urandom % 5, k * 4);
				landing[i + k] = 1'b1;
			end else if (t == 4 && !landing[i + 1]) begin
				prog[i] = enc_i(isa_pkg::OPC_OP_IMM, 5, 0, (i + 1 + k) * 4); // jump target.
				prog[i + 1] = enc_i(isa_pkg::OPC_JALR, $urandom % 5, 5, 0);
				i++;
			end else begin
				prog[i] = random_alu(5, 1'b1);
			end
			i++;
		end
	endtask

	task automatic gen_x0();
		prog_len = 32;
		for (int i = 0; i < prog_len; i++) begin
			case ($urandom % 4)
				0: prog[i] = {25'($urandom), ($urandom % 2) ? 7'b0000011 : 7'b1110011};
				1: prog[i] = enc_i(isa_pkg::OPC_OP_IMM, 0, 1 + $urandom % 3, 7);
				2: prog[i] = enc_r(1 + $urandom % 3, 0, 0); // reads x0.
				default: prog[i] = random_alu(4, 1'b1);
			endcase
		end
	endtask

	// ************************************************************************
	// fetch driver and retire checker.
	// ************************************************************************
	always @(negedge clock) begin
		reset = hold_reset;
		inst_valid = running && fetch_pc < prog_len * 4;
		inst = prog[fetch_pc[7:2]];
		inst_pc = fetch_pc;
		retire_ready = !bp_on || ($urandom % 4 != 0);
	end

	always @(posedge clock) begin
		if (!reset && redirect_valid) fetch_pc = redirect_pc;
		else if (!reset && inst_valid && inst_ready) fetch_pc = fetch_pc + 4;
		if (!reset && retire_valid && retire_ready) begin
			if (exp_pc.size() == 0) begin
				$display("unexpected retire at pc %h after the last instruction", retire_pc);
				errors++;
			end else begin
				check_value("retire_pc", retire_pc, exp_pc.pop_front());
				check_value("retire_rd", 32'(retire_rd), 32'(exp_rd.pop_front()));
				check_value("retire_wen", 32'(retire_wen), 32'(exp_wen.pop_front()));
				check_value("retire_value", retire_value, exp_val.pop_front());
			end
			retired++;
		end
	end

	task automatic run_program(input string name, input logic bp);
		isa_pkg::word_t pc, npc, val;
		logic [4:0] rd;
		logic wen;
		int steps, count, cycles, errors_before;
		errors_before = errors;
		@(posedge clock);
		running = 1'b0;
		hold_reset = 1'b1;
		bp_on = bp;
		for (int i = 0; i < REG_COUNT; i++) model_regs[i] = '0;
		pc = '0;
		steps = 0;
		while (pc < prog_len * 4 && steps < 500) begin
			golden_step(pc, npc, rd, val, wen);
			exp_pc.push_back(pc);
			exp_rd.push_back(rd);
			exp_val.push_back(val);
			exp_wen.push_back(wen);
			pc = npc;
			steps++;
		end
		count = steps;
		for (int i = 0; i < 10; i++) begin
			@(posedge clock);
			if (i >= 1) begin
				check_value("retire_valid", 32'(retire_valid), 0);
				check_value("redirect_valid", 32'(redirect_valid), 0);
				check_value("inst_ready", 32'(inst_ready), 1);
			end
		end
		hold_reset = 1'b0;
		@(posedge clock);
		@(posedge clock);
		check_value("retire_valid", 32'(retire_valid), 0);
		check_value("redirect_valid", 32'(redirect_valid), 0);
		check_value("inst_ready", 32'(inst_ready), 1);
		fetch_pc = '0;
		retired = 0;
		running = 1'b1;
		cycles = 0;
		while (retired < count && cycles < 3000) begin
			@(posedge clock);
			cycles++;
		end
		if (retired < count) begin
			$display("no retire within timeout in %s", name);
			errors++;
		end
		repeat (20) @(posedge clock); // anything retiring now is extra.
		running = 1'b0;
		if (retired != count) begin
			$display("%s retired %0d instructions instead of %0d", name, retired, count);
			errors++;
		end
		exp_pc.delete();
		exp_rd.delete();
		exp_val.delete();
		exp_wen.delete();
		tests++;
		if (errors != errors_before) failed_tests++;
		$display("test %s: %0d retired, %0d errors", name, retired, errors - errors_before);
	endtask

	initial begin
		int unsigned seed;
		reset = 1'b1;
		hold_reset = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		inst_pc = '0;
		retire_ready = 1'b1;
		running = 1'b0;
		bp_on = 1'b0;
		fetch_pc = '0;
		prog_len = 0;
		errors = 0;
		tests = 0;
		failed_tests = 0;
		retired = 0;
		seed = $urandom(78220);
		gen_dep();
		run_program("dependency_chains", 1'b0);
		gen_mix();
		run_program("alu_mix_backpressure", 1'b1);
		gen_ctrl();
		run_program("control_flow", 1'b1);
		gen_x0();
		run_program("x0_and_unknown", 1'b0);
		$display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== src.f ====
rtl/isa_pkg.sv
rtl/uop_pkg.sv
rtl/instr_decoder.sv
rtl/register_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/rv_pipe_core.sv
verification/core_properties.sv
verification/core_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the pipeline testbench.

TOP := core_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)
	verilator --lint-only -f src.f --top-module rv_pipe_core

clean:
	rm -rf obj_dir $(LOG)
